/* rtl/host_bus_pkg.sv */
package host_bus_pkg;

   // Register window word as seen on the lite bus
   localparam int lite_data_width = 32;

   // Byte lanes per word, one write strobe bit each
   localparam int lite_lanes = 4;

   // Number of words in the register window
   localparam int lite_depth = 32;

   // The lite bus carries a full byte address
   localparam int lite_addr_width = 32;

   // One register word, written lane by lane and read back whole
   typedef union packed {
      logic [lite_data_width-1:0]  word;
      logic [lite_lanes-1:0][7:0] lane;
   } lite_word_u;

   // Scratch RAM is byte wide
   localparam int mem_data_width = 8;

   // 32 bytes of scratch RAM
   localparam int mem_addr_width = 5;

endpackage

/* rtl/dac_pkg.sv */
package dac_pkg;

   // Number of DAC channels fed by the host
   localparam int dac_channels = 4;

   // Each channel sample is one full host word
   localparam int dac_sample_width = 32;

   // Serial data pins toward the DAC chips
   // Each pin carries an even channel in the low word-clock half
   // and the following odd channel in the high half
   localparam int dac_data_pins = 2;

endpackage

/* rtl/lite_register_bank.sv */
`timescale 1ns/1ps

module lite_register_bank
(
   input  logic                                     bus_clk,
   input  logic                                     rst_n,
   input  logic                                     lite_wren,
   input  logic [host_bus_pkg::lite_lanes-1:0]      lite_wstrb,
   input  logic [host_bus_pkg::lite_addr_width-1:0] lite_addr,
   input  host_bus_pkg::lite_word_u                 lite_wr_data,
   input  logic                                     lite_rden,
   output host_bus_pkg::lite_word_u                 lite_rd_data
);

   // Width of the word index taken from the byte address
   localparam int index_width = $clog2(host_bus_pkg::lite_depth);

   host_bus_pkg::lite_word_u bank [host_bus_pkg::lite_depth];
   logic [index_width-1:0]   word_index;

   // The two low address bits select a byte inside the word and are dropped
   assign word_index = lite_addr[index_width+1:2];

   // Each strobed lane is written on its own
   // Lanes without a strobe keep their old byte
   always_ff @(posedge bus_clk)
   begin
      for (int i = 0; i < host_bus_pkg::lite_lanes; i++)
      begin
         if (lite_wren && lite_wstrb[i])
         begin
            bank[word_index].lane[i] <= lite_wr_data.lane[i];
         end
      end
   end

   // Read data is registered and held until the next read
   // A read and a write to the same word in one cycle returns the old word
   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         lite_rd_data.word <= '0;
      end
      else if (lite_rden)
      begin
         lite_rd_data.word <= bank[word_index].word;
      end
   end

   // Strobes carry meaning only together with the write enable,
   // so the bus keeps them at zero between writes
   a_strobe_idle : assert property (
      @(posedge bus_clk) disable iff (!rst_n)
      !lite_wren |-> lite_wstrb == '0
   );

endmodule

/* rtl/byte_ram.sv */
`timescale 1ns/1ps

module byte_ram
(
   input  logic                                    bus_clk,
   input  logic                                    rst_n,
   input  logic                                    mem_wren,
   input  logic                                    mem_rden,
   input  logic [host_bus_pkg::mem_addr_width-1:0] mem_addr,
   input  logic [host_bus_pkg::mem_data_width-1:0] mem_wr_data,
   output logic [host_bus_pkg::mem_data_width-1:0] mem_rd_data
);

   // One byte per address over the whole address range
   localparam int ram_depth = 2 ** host_bus_pkg::mem_addr_width;

   logic [host_bus_pkg::mem_data_width-1:0] ram [ram_depth];

   // Plain write port, one byte per cycle
   always_ff @(posedge bus_clk)
   begin
      if (mem_wren)
      begin
         ram[mem_addr] <= mem_wr_data;
      end
   end

   // Registered read port with one cycle of latency
   // The array is read before this edge's write lands, so a same-address
   // read and write gives back the previous byte
   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         mem_rd_data <= '0;
      end
      else if (mem_rden)
      begin
         mem_rd_data <= ram[mem_addr];
      end
   end

endmodule

/* rtl/dac_frame_control.sv */
`timescale 1ns/1ps

module dac_frame_control
#(
   parameter int bck_half_cycles = 2
)
(
   input  logic bus_clk,
   input  logic rst_n,
   input  logic dac_open,
   output logic dac_not_rst,
   output logic dac_bck,
   output logic dac_lrck,
   output logic frame_request,
   output logic bit_advance
);

   // Bus clock cycles in one bit-clock period
   localparam int period_cycles = 2 * bck_half_cycles;
   localparam int sub_width = $clog2(period_cycles);

   // A frame holds two samples per pin, one per word-clock half
   localparam int frame_bits = 2 * dac_pkg::dac_sample_width;
   localparam int bit_width = $clog2(frame_bits);

   logic                 open_q;
   logic                 running;
   logic [sub_width-1:0] sub_cnt;
   logic [bit_width-1:0] bit_cnt;
   logic [sub_width-1:0] sub_next;
   logic [bit_width-1:0] bit_next;
   logic                 period_end;
   logic                 frame_last;

   // sub_cnt is the bus cycle inside a bit period, bit_cnt the period inside the frame
   assign period_end = sub_cnt == sub_width'(period_cycles - 1);
   assign frame_last = bit_cnt == bit_width'(frame_bits - 1);
   assign sub_next = period_end ? '0 : sub_cnt + 1'b1;
   assign bit_next = period_end ? bit_cnt + 1'b1 : bit_cnt;

   // The last cycle of every period ends in a falling bit-clock edge
   assign bit_advance = dac_not_rst && period_end;

   // Frame request sits one cycle ahead of the frame's first falling edge
   // This leaves the buffer a cycle to register its load strobe
   assign frame_request = dac_not_rst && frame_last &&
                          (sub_cnt == sub_width'(period_cycles - 2));

   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         open_q      <= 1'b0;
         dac_not_rst <= 1'b0;
         running     <= 1'b0;
         sub_cnt     <= sub_width'(period_cycles - 2);
         bit_cnt     <= '1;
         dac_bck     <= 1'b0;
         dac_lrck    <= 1'b0;
      end
      else if (!dac_open)
      begin
         // While the device is closed the counters park just ahead of a frame request
         open_q      <= 1'b0;
         dac_not_rst <= 1'b0;
         running     <= 1'b0;
         sub_cnt     <= sub_width'(period_cycles - 2);
         bit_cnt     <= '1;
         dac_bck     <= 1'b0;
         dac_lrck    <= 1'b0;
      end
      else
      begin
         // DAC reset releases two cycles after open
         open_q      <= 1'b1;
         dac_not_rst <= open_q;
         if (dac_not_rst)
         begin
            sub_cnt <= sub_next;
            bit_cnt <= bit_next;
            if (bit_advance && frame_last)
            begin
               running <= 1'b1;
            end
            // Until the first frame begins both clocks stay low
            // Clocks are decoded from the next count so they line up with it
            dac_bck  <= running && (sub_next >= sub_width'(bck_half_cycles));
            dac_lrck <= running && bit_next[bit_width-1];
         end
      end
   end

   // The request must never land on a shift cycle
   // Once the clocks run it sits in the high bit-clock half of the frame's last period
   a_request_apart : assert property (
      @(posedge bus_clk) disable iff (!rst_n)
      frame_request |-> !bit_advance && dac_bck == running && dac_lrck == running
   );

endmodule

/* rtl/dac_sample_buffer.sv */
`timescale 1ns/1ps

module dac_sample_buffer
(
   input  logic                                                      bus_clk,
   input  logic                                                      rst_n,
   input  logic                                                      dac_open,
   input  logic                                                      dac_wr_en,
   input  logic [dac_pkg::dac_sample_width-1:0]                      dac_wr_data,
   input  logic                                                      frame_request,
   output logic                                                      dac_wr_full,
   output logic                                                      dac_underrun,
   output logic                                                      load_strobe,
   output logic [dac_pkg::dac_channels*dac_pkg::dac_sample_width-1:0] active_samples
);

   localparam int slot_width = $clog2(dac_pkg::dac_channels);

   logic [dac_pkg::dac_channels-1:0][dac_pkg::dac_sample_width-1:0] staging;
   logic [slot_width-1:0]                                           slot;
   logic                                                            slot_last;
   logic                                                            accept;
   logic                                                            transfer;

   assign slot_last = slot == slot_width'(dac_pkg::dac_channels - 1);

   // A write while full is dropped
   assign accept = dac_wr_en && !dac_wr_full;

   // Only a complete set moves to the active registers
   assign transfer = frame_request && dac_wr_full;

   // Slot counter, full flag and the frame-start outcome pulses
   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         slot         <= '0;
         dac_wr_full  <= 1'b0;
         dac_underrun <= 1'b0;
         load_strobe  <= 1'b0;
      end
      else if (!dac_open)
      begin
         slot         <= '0;
         dac_wr_full  <= 1'b0;
         dac_underrun <= 1'b0;
         load_strobe  <= 1'b0;
      end
      else
      begin
         load_strobe  <= transfer;
         dac_underrun <= frame_request && !dac_wr_full;
         if (transfer)
         begin
            dac_wr_full <= 1'b0;
            slot        <= '0;
         end
         else if (accept)
         begin
            slot <= slot_last ? '0 : slot + 1'b1;
            if (slot_last)
            begin
               dac_wr_full <= 1'b1;
            end
         end
      end
   end

   // Staging fills in channel order and is wiped while the device is closed
   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         staging <= '0;
      end
      else if (!dac_open)
      begin
         staging <= '0;
      end
      else if (accept)
      begin
         staging[slot] <= dac_wr_data;
      end
   end

   // Active samples stay put on an underrun so the last frame repeats
   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         active_samples <= '0;
      end
      else if (dac_open && transfer)
      begin
         active_samples <= staging;
      end
   end

   // The host holds back its write strobe while the set is full
   a_no_write_full : assert property (
      @(posedge bus_clk) disable iff (!rst_n)
      dac_wr_full |-> !dac_wr_en
   );

endmodule

/* rtl/dac_shift_out.sv */
`timescale 1ns/1ps

module dac_shift_out
(
   input  logic                                                      bus_clk,
   input  logic                                                      rst_n,
   input  logic                                                      load_strobe,
   input  logic                                                      bit_advance,
   input  logic                                                      dac_lrck,
   input  logic [dac_pkg::dac_channels*dac_pkg::dac_sample_width-1:0] active_samples,
   output logic [dac_pkg::dac_data_pins-1:0]                         dac_data
);

   localparam int width = dac_pkg::dac_sample_width;

   logic [dac_pkg::dac_data_pins-1:0][width-1:0] even_sr;
   logic [dac_pkg::dac_data_pins-1:0][width-1:0] odd_sr;

   // The registers rotate rather than shift
   // After a full frame each one is back at its loaded value,
   // so a frame with no load sends the same samples again
   always_ff @(posedge bus_clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         even_sr <= '0;
         odd_sr  <= '0;
      end
      else if (load_strobe)
      begin
         // Pin p carries channels 2p and 2p+1
         for (int p = 0; p < dac_pkg::dac_data_pins; p++)
         begin
            even_sr[p] <= active_samples[2*p*width +: width];
            odd_sr[p]  <= active_samples[(2*p+1)*width +: width];
         end
      end
      else if (bit_advance)
      begin
         // Only the half now on the pins moves, MSB first
         for (int p = 0; p < dac_pkg::dac_data_pins; p++)
         begin
            if (dac_lrck)
            begin
               odd_sr[p] <= {odd_sr[p][width-2:0], odd_sr[p][width-1]};
            end
            else
            begin
               even_sr[p] <= {even_sr[p][width-2:0], even_sr[p][width-1]};
            end
         end
      end
   end

   // Word clock picks which register drives each pin
   always_comb
   begin
      for (int p = 0; p < dac_pkg::dac_data_pins; p++)
      begin
         dac_data[p] = dac_lrck ? odd_sr[p][width-1] : even_sr[p][width-1];
      end
   end

   // A load replaces the frame's first falling edge, so it must coincide
   // with a bit advance from the frame controller
   a_load_on_edge : assert property (
      @(posedge bus_clk) disable iff (!rst_n)
      load_strobe |-> bit_advance
   );

endmodule

/* rtl/ilemt_host_top.sv */
`timescale 1ns/1ps

module ilemt_host_top
#(
   parameter int bck_half_cycles = 2
)
(
   input  logic                                     bus_clk,
   input  logic                                     rst_n,
   // Lite register window
   input  logic                                     lite_wren,
   input  logic [host_bus_pkg::lite_lanes-1:0]      lite_wstrb,
   input  logic [host_bus_pkg::lite_addr_width-1:0] lite_addr,
   input  logic [host_bus_pkg::lite_data_width-1:0] lite_wr_data,
   input  logic                                     lite_rden,
   output host_bus_pkg::lite_word_u                 lite_rd_data,
   // Scratch RAM
   input  logic                                     mem_wren,
   input  logic [host_bus_pkg::mem_addr_width-1:0]  mem_addr,
   input  logic [host_bus_pkg::mem_data_width-1:0]  mem_wr_data,
   input  logic                                     mem_rden,
   output logic [host_bus_pkg::mem_data_width-1:0]  mem_rd_data,
   // DAC host side
   input  logic                                     dac_open,
   input  logic                                     dac_wr_en,
   input  logic [dac_pkg::dac_sample_width-1:0]     dac_wr_data,
   output logic                                     dac_wr_full,
   output logic                                     dac_underrun,
   // DAC pins
   output logic                                     dac_bck,
   output logic                                     dac_lrck,
   output logic                                     dac_not_rst,
   output logic [dac_pkg::dac_data_pins-1:0]        dac_data
);

   logic                                                      frame_request;
   logic                                                      bit_advance;
   logic                                                      load_strobe;
   logic [dac_pkg::dac_channels*dac_pkg::dac_sample_width-1:0] active_samples;

   lite_register_bank u_lite_bank (
      .bus_clk      (bus_clk),
      .rst_n        (rst_n),
      .lite_wren    (lite_wren),
      .lite_wstrb   (lite_wstrb),
      .lite_addr    (lite_addr),
      .lite_wr_data (lite_wr_data),
      .lite_rden    (lite_rden),
      .lite_rd_data (lite_rd_data)
   );

   byte_ram u_byte_ram (
      .bus_clk     (bus_clk),
      .rst_n       (rst_n),
      .mem_wren    (mem_wren),
      .mem_rden    (mem_rden),
      .mem_addr    (mem_addr),
      .mem_wr_data (mem_wr_data),
      .mem_rd_data (mem_rd_data)
   );

   // Bit clock, word clock and DAC reset come from the frame controller
   dac_frame_control #(
      .bck_half_cycles (bck_half_cycles)
   ) u_frame_control (
      .bus_clk       (bus_clk),
      .rst_n         (rst_n),
      .dac_open      (dac_open),
      .dac_not_rst   (dac_not_rst),
      .dac_bck       (dac_bck),
      .dac_lrck      (dac_lrck),
      .frame_request (frame_request),
      .bit_advance   (bit_advance)
   );

   // Host words gather here until a frame start takes them
   dac_sample_buffer u_sample_buffer (
      .bus_clk        (bus_clk),
      .rst_n          (rst_n),
      .dac_open       (dac_open),
      .dac_wr_en      (dac_wr_en),
      .dac_wr_data    (dac_wr_data),
      .frame_request  (frame_request),
      .dac_wr_full    (dac_wr_full),
      .dac_underrun   (dac_underrun),
      .load_strobe    (load_strobe),
      .active_samples (active_samples)
   );

   dac_shift_out u_shift_out (
      .bus_clk        (bus_clk),
      .rst_n          (rst_n),
      .load_strobe    (load_strobe),
      .bit_advance    (bit_advance),
      .dac_lrck       (dac_lrck),
      .active_samples (active_samples),
      .dac_data       (dac_data)
   );

endmodule

/* verification/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen
#(
   parameter int period_ns    = 100,
   parameter int reset_cycles = 10
)
(
   output logic bus_clk,
   output logic rst_n
);

   // Free-running bus clock with an even duty cycle
   initial
   begin
      bus_clk = 1'b0;
      forever
      begin
         #(period_ns / 2.0) bus_clk = ~bus_clk;
      end
   end

   // Reset holds over the first cycles and lets go on a rising edge
   initial
   begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge bus_clk);
      rst_n <= 1'b1;
   end

endmodule

/* verification/tb_ilemt_host.sv */
`timescale 1ns/1ps

module tb_ilemt_host;

   localparam int bck_half_cycles = 2;
   localparam int period_ns       = 100;
   localparam int reset_cycles    = 10;
   // A frame is 64 bit-clock periods of 4 bus cycles each
   localparam int frame_cycles    = 64 * 2 * bck_half_cycles;
   localparam int lite_rounds     = 48;
   localparam int ram_rounds      = 64;
   localparam int dac_frames      = 12;
   // Bank fill, write plus two reads per round, RAM fill and accesses, then the DAC frames
   localparam longint run_cycles  = reset_cycles + 32 * 2 + lite_rounds * 8 + 32 * 2 +
                                    ram_rounds * 4 + dac_frames * frame_cycles;
   localparam longint watchdog_ns = (run_cycles + 2 * frame_cycles) * period_ns;

   logic                     bus_clk;
   logic                     rst_n;
   logic                     lite_wren;
   logic [3:0]               lite_wstrb;
   logic [31:0]              lite_addr;
   logic [31:0]              lite_wr_data;
   logic                     lite_rden;
   host_bus_pkg::lite_word_u lite_rd_data;
   logic                     mem_wren;
   logic [4:0]               mem_addr;
   logic [7:0]               mem_wr_data;
   logic                     mem_rden;
   logic [7:0]               mem_rd_data;
   logic                     dac_open;
   logic                     dac_wr_en;
   logic [31:0]              dac_wr_data;
   logic                     dac_wr_full;
   logic                     dac_underrun;
   logic                     dac_bck;
   logic                     dac_lrck;
   logic                     dac_not_rst;
   logic [1:0]               dac_data;

   // Reference models and the values the checks compare
   logic [31:0]       lite_model [32];
   logic [7:0]        ram_model [32];
   logic [31:0]       lite_exp;
   logic              lite_check;
   logic [7:0]        mem_exp;
   logic              mem_check;
   logic [127:0]      staged_model = '0;
   logic [127:0]      active_model = '0;
   logic [127:0]      rx_frame;
   logic [127:0]      exp_frame;
   logic              frame_done = 1'b0;
   int                frames_done = 0;
   int                underruns = 0;
   logic [1:0][31:0]  even_acc;
   logic [1:0][31:0]  odd_acc;
   int                even_cnt = 0;
   int                odd_cnt = 0;
   logic              bck_prev = 1'b0;
   logic              full_prev = 1'b0;
   logic [31:0]       rng_state;
   string             dac_phase = "idle";
   int                lite_errors = 0;
   int                ram_errors = 0;
   int                dac_errors = 0;
   int                other_errors = 0;

   clock_gen #(.period_ns(period_ns), .reset_cycles(reset_cycles)) u_clock_gen (
      .bus_clk (bus_clk),
      .rst_n   (rst_n)
   );

   ilemt_host_top #(.bck_half_cycles(bck_half_cycles)) dut (
      .bus_clk      (bus_clk),
      .rst_n        (rst_n),
      .lite_wren    (lite_wren),
      .lite_wstrb   (lite_wstrb),
      .lite_addr    (lite_addr),
      .lite_wr_data (lite_wr_data),
      .lite_rden    (lite_rden),
      .lite_rd_data (lite_rd_data),
      .mem_wren     (mem_wren),
      .mem_addr     (mem_addr),
      .mem_wr_data  (mem_wr_data),
      .mem_rden     (mem_rden),
      .mem_rd_data  (mem_rd_data),
      .dac_open     (dac_open),
      .dac_wr_en    (dac_wr_en),
      .dac_wr_data  (dac_wr_data),
      .dac_wr_full  (dac_wr_full),
      .dac_underrun (dac_underrun),
      .dac_bck      (dac_bck),
      .dac_lrck     (dac_lrck),
      .dac_not_rst  (dac_not_rst),
      .dac_data     (dac_data)
   );

   // 32-bit xorshift step
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // Only the strobed lanes of the model take the new bytes
   task automatic lite_write(input int idx, input logic [3:0] strb, input logic [31:0] data);
      @(posedge bus_clk);
      lite_wren    <= 1'b1;
      lite_wstrb   <= strb;
      lite_addr    <= 32'(idx) << 2;
      lite_wr_data <= data;
      for (int i = 0; i < 4; i++)
      begin
         if (strb[i])
         begin
            lite_model[idx][8*i +: 8] = data[8*i +: 8];
         end
      end
      @(posedge bus_clk);
      lite_wren  <= 1'b0;
      lite_wstrb <= '0;
   endtask

   // The check flag rises one cycle after the read strobe
   task automatic lite_read(input int idx);
      @(posedge bus_clk);
      lite_rden <= 1'b1;
      lite_addr <= 32'(idx) << 2;
      lite_exp  <= lite_model[idx];
      @(posedge bus_clk);
      lite_rden  <= 1'b0;
      lite_check <= 1'b1;
      @(posedge bus_clk);
      lite_check <= 1'b0;
   endtask

   task automatic ram_access(input int addr, input logic wr, input logic [7:0] data,
                             input logic rd);
      @(posedge bus_clk);
      mem_wren    <= wr;
      mem_rden    <= rd;
      mem_addr    <= 5'(addr);
      mem_wr_data <= data;
      // A read in the same cycle as a write sees the byte from before it
      mem_exp     <= ram_model[addr];
      if (wr)
      begin
         ram_model[addr] = data;
      end
      @(posedge bus_clk);
      mem_wren  <= 1'b0;
      mem_rden  <= 1'b0;
      mem_check <= rd;
      if (rd)
      begin
         @(posedge bus_clk);
         mem_check <= 1'b0;
      end
   endtask

   // Four words go into slots 0 to 3 in order
   task automatic write_dac_set();
      logic [31:0] w;
      for (int i = 0; i < 4; i++)
      begin
         w = next_random();
         @(posedge bus_clk);
         dac_wr_en   <= 1'b1;
         dac_wr_data <= w;
         staged_model[32*i +: 32] = w;
      end
      @(posedge bus_clk);
      dac_wr_en <= 1'b0;
   endtask

   task automatic wait_for_full(input logic level);
      @(negedge bus_clk);
      while (dac_wr_full !== level)
      begin
         @(negedge bus_clk);
      end
   endtask

   task automatic wait_for_frame();
      int target;
      target = frames_done + 1;
      while (frames_done < target)
      begin
         @(negedge bus_clk);
      end
   endtask

   task automatic wait_for_underrun();
      int target;
      target = underruns + 1;
      while (underruns < target)
      begin
         @(negedge bus_clk);
      end
   endtask

   // The pin monitor takes bits at bit-clock rising edges and splits them by the word clock
   // A full set is staged into the active model when the full flag drops
   always @(negedge bus_clk)
   begin
      frame_done <= 1'b0;
      if (dac_underrun)
      begin
         underruns <= underruns + 1;
      end
      if (full_prev && !dac_wr_full)
      begin
         active_model = staged_model;
      end
      if (dac_bck && !bck_prev)
      begin
         for (int p = 0; p < 2; p++)
         begin
            if (dac_lrck)
            begin
               odd_acc[p] = {odd_acc[p][30:0], dac_data[p]};
            end
            else
            begin
               even_acc[p] = {even_acc[p][30:0], dac_data[p]};
            end
         end
         if (dac_lrck)
         begin
            odd_cnt++;
         end
         else
         begin
            even_cnt++;
         end
         if (odd_cnt == 32)
         begin
            a_halves : assert (even_cnt == 32)
            else
            begin
               other_errors++;
               $display("A DAC frame did not split into two halves of 32 bits");
            end
            rx_frame    <= {odd_acc[1], even_acc[1], odd_acc[0], even_acc[0]};
            exp_frame   <= active_model;
            frame_done  <= 1'b1;
            frames_done <= frames_done + 1;
            odd_cnt = 0;
            even_cnt = 0;
         end
      end
      bck_prev  = dac_bck;
      full_prev = dac_wr_full;
   end

   // Closed device keeps every DAC output quiet
   a_idle : assert property (@(posedge bus_clk) disable iff (!rst_n)
      !dac_open |-> !dac_bck && !dac_lrck && dac_data == '0 && !dac_not_rst &&
                    !dac_wr_full && !dac_underrun)
   else
   begin
      other_errors++;
      $display("DAC outputs were active while the device was closed");
   end

   a_lite_read : assert property (@(posedge bus_clk) disable iff (!rst_n)
      lite_check |-> lite_rd_data.word == lite_exp)
   else
   begin
      lite_errors++;
      $display("error register_window expected %h actual %h",
               $sampled(lite_exp), $sampled(lite_rd_data.word));
   end

   a_lite_hold : assert property (@(posedge bus_clk) disable iff (!rst_n)
      !$past(lite_rden) |-> $stable(lite_rd_data.word))
   else
   begin
      other_errors++;
      $display("Register window read data changed without a read");
   end

   a_ram_read : assert property (@(posedge bus_clk) disable iff (!rst_n)
      mem_check |-> mem_rd_data == mem_exp)
   else
   begin
      ram_errors++;
      $display("error scratch_ram expected %h actual %h",
               $sampled(mem_exp), $sampled(mem_rd_data));
   end

   // Each received frame carries the set that was active at its start
   a_frame_words : assert property (@(posedge bus_clk) disable iff (!rst_n)
      frame_done |-> rx_frame == exp_frame)
   else
   begin
      dac_errors++;
      $display("error %s expected %h actual %h",
               dac_phase, $sampled(exp_frame), $sampled(rx_frame));
   end

   a_underrun_cause : assert property (@(posedge bus_clk) disable iff (!rst_n)
      dac_underrun |-> !$past(dac_wr_full))
   else
   begin
      other_errors++;
      $display("Underrun pulsed while a full sample set was waiting");
   end

   // The word clock falls at a frame start one cycle after the full flag drops
   a_full_at_frame : assert property (@(posedge bus_clk) disable iff (!rst_n)
      $fell(dac_wr_full) |=> $fell(dac_lrck))
   else
   begin
      other_errors++;
      $display("The full flag dropped away from a frame start");
   end

   // Watchdog sized from the summed test lengths
   initial
   begin
      #(watchdog_ns);
      $display("Timeout, the run did not finish within %0d ns", watchdog_ns);
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial
   begin
      logic [31:0] r;
      lite_wren    = 1'b0;
      lite_wstrb   = '0;
      lite_addr    = '0;
      lite_wr_data = '0;
      lite_rden    = 1'b0;
      lite_check   = 1'b0;
      mem_wren     = 1'b0;
      mem_addr     = '0;
      mem_wr_data  = '0;
      mem_rden     = 1'b0;
      mem_check    = 1'b0;
      dac_open     = 1'b0;
      dac_wr_en    = 1'b0;
      dac_wr_data  = '0;
      rng_state    = 32'd19954;
      while (rst_n !== 1'b1)
      begin
         @(negedge bus_clk);
      end

      // The DAC stays closed through the bus tests, so the idle check runs all along
      for (int i = 0; i < 32; i++)
      begin
         lite_write(i, 4'hf, next_random());
      end
      for (int i = 0; i < lite_rounds; i++)
      begin
         r = next_random();
         lite_write(r[4:0], r[8:5], next_random());
         lite_read(r[4:0]);
         lite_read(r[13:9]);
      end

      for (int i = 0; i < 32; i++)
      begin
         ram_access(i, 1'b1, next_random(), 1'b0);
      end
      // Op 0 writes, op 1 reads, ops 2 and 3 read and write one address together
      for (int i = 0; i < ram_rounds; i++)
      begin
         r = next_random();
         ram_access(r[6:2], r[1:0] != 2'd1, r[15:8], r[1:0] != 2'd0);
      end

      dac_phase = "dac_serial";
      @(posedge bus_clk);
      dac_open <= 1'b1;
      write_dac_set();
      wait_for_full(1'b1);
      wait_for_full(1'b0);
      wait_for_frame();

      // No new set, so the next frame start reports underrun and repeats
      dac_phase = "underrun_repeat";
      wait_for_underrun();
      wait_for_frame();

      dac_phase = "back_pressure";
      write_dac_set();
      wait_for_full(1'b1);
      wait_for_full(1'b0);
      write_dac_set();
      wait_for_full(1'b1);
      wait_for_full(1'b0);
      wait_for_frame();
      repeat (4) @(posedge bus_clk);

      $display("Errors: register window %0d, scratch ram %0d, dac %0d, other %0d",
               lite_errors, ram_errors, dac_errors, other_errors);
      if (lite_errors + ram_errors + dac_errors + other_errors == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* sources.f */
rtl/host_bus_pkg.sv
rtl/dac_pkg.sv
rtl/lite_register_bank.sv
rtl/byte_ram.sv
rtl/dac_frame_control.sv
rtl/dac_sample_buffer.sv
rtl/dac_shift_out.sv
rtl/ilemt_host_top.sv
verification/clock_gen.sv
verification/tb_ilemt_host.sv

/* Bender.yml */
package:
  name: ilemt_host

sources:
  - rtl/host_bus_pkg.sv
  - rtl/dac_pkg.sv
  - rtl/lite_register_bank.sv
  - rtl/byte_ram.sv
  - rtl/dac_frame_control.sv
  - rtl/dac_sample_buffer.sv
  - rtl/dac_shift_out.sv
  - rtl/ilemt_host_top.sv
  - target: simulation
    files:
      - verification/clock_gen.sv
      - verification/tb_ilemt_host.sv
